//--- source/swerve_types_pkg.sv
/*
 * Widths and motor counts shared by every part of the swerve register block.
 * Import with swerve_types_pkg::* in the module header.
 */
package swerve_types_pkg;

    localparam int NUM_DRIVE = 4;  // Drive wheels
    localparam int NUM_ROT   = 4;  // Steering units

    // Host bus
    typedef logic [5:0]  addr_t;   // 64 register slots
    typedef logic [7:0]  data_t;   // One register byte

    // Drive motor fields
    typedef logic [4:0]  pwm_t;    // PWM level, low bits of drive control
    typedef logic [5:0]  temp_t;   // Raw ADC temperature

    // Rotation motor fields
    typedef logic [11:0] angle_t;     // Full steering angle
    typedef logic [3:0]  angle_hi_t;  // Angle bits above the low byte

endpackage

//--- source/swerve_map_pkg.sv
/*
 * Register address map and field bit positions of the swerve register block.
 * Address helpers here are used by both the write decode and the read mux.
 */
package swerve_map_pkg;

    import swerve_types_pkg::*;

    // Broadcast slots, write only
    localparam addr_t ADDR_BCAST_ALL   = 6'h01;  // Every motor control register
    localparam addr_t ADDR_BCAST_ROT   = 6'h02;  // Rotation controls only
    localparam addr_t ADDR_BCAST_DRIVE = 6'h03;  // Drive controls only

    // Drive unit i: control at base+2i, status right after
    localparam addr_t ADDR_DRIVE_BASE  = 6'h04;

    // Rotation unit i: four slots from base+4i
    localparam addr_t ADDR_ROT_BASE    = 6'h0C;
    localparam int    ROT_STRIDE       = 4;
    localparam int    ROT_OFS_CTRL     = 0;  // Brake, enable, direction, target hi
    localparam int    ROT_OFS_TGT_LO   = 1;  // Target angle low byte
    localparam int    ROT_OFS_CUR_LO   = 2;  // Snapshot low byte, read only
    localparam int    ROT_OFS_CMD      = 3;  // Command on write, status on read

    // Control byte fields, same for drive and rotation
    localparam int BIT_BRAKE     = 7;
    localparam int BIT_ENABLE    = 6;
    localparam int BIT_DIRECTION = 5;

    // Command byte fields
    localparam int BIT_ABORT  = 4;
    localparam int BIT_UPDATE = 5;
    localparam int BIT_SNAP   = 6;
    localparam int BIT_DONE   = 7;  // Read side of the command slot

    // Address of a drive register, status selects the odd slot
    function automatic addr_t drive_addr(input int unit, input bit status);
        return addr_t'(ADDR_DRIVE_BASE + 2 * unit + int'(status));
    endfunction

    // Address of one register within a rotation unit
    function automatic addr_t rot_addr(input int unit, input int ofs);
        return addr_t'(ADDR_ROT_BASE + ROT_STRIDE * unit + ofs);
    endfunction

endpackage

//--- source/rot_readback_if.sv
/*
 * Rotation register contents on their way from the rotation bank to the read mux.
 * The bank drives everything, the mux only looks.
 */
`timescale 1ns/1ps

interface rot_readback_if
    import swerve_types_pkg::*;
();

    data_t  [NUM_ROT-1:0] rot_ctrl;    // Control bytes
    data_t  [NUM_ROT-1:0] rot_tgt_lo;  // Target angle low bytes
    angle_t [NUM_ROT-1:0] rot_snap;    // Captured angles
    logic   [NUM_ROT-1:0] rot_done;    // angle_done, one clock late

    modport bank (
        output rot_ctrl,
        output rot_tgt_lo,
        output rot_snap,
        output rot_done
    );

    modport mux (
        input rot_ctrl,
        input rot_tgt_lo,
        input rot_snap,
        input rot_done
    );

endinterface

//--- source/drive_bank.sv
/*
 * Drive motor control registers with broadcast writes, plus per-clock status sampling.
 * Control bytes go to the motor outputs and both byte sets go to the read mux.
 */
`timescale 1ns/1ps

module drive_bank
    import swerve_types_pkg::*, swerve_map_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  addr_t                 address,       // Host register address
    input  logic                  write_en,      // Host write strobe
    input  data_t                 wr_data,       // Host write byte
    input  logic [NUM_DRIVE-1:0]  fault,         // Motor driver fault
    input  logic [NUM_DRIVE-1:0]  startup_fail,  // Motor failed to spin up
    input  temp_t [NUM_DRIVE-1:0] adc_temp,      // Driver temperature
    output data_t [NUM_DRIVE-1:0] drive_ctrl,    // Brake, enable, dir, pwm
    output data_t [NUM_DRIVE-1:0] drive_status   // Fault, fail, temperature
);

    logic                 bcast_hit;  // Write lands on every drive unit
    logic [NUM_DRIVE-1:0] ctrl_we;    // Per-unit control write

    // All-motor and drive-only broadcasts
    assign bcast_hit = (address == ADDR_BCAST_ALL) || (address == ADDR_BCAST_DRIVE);

    always_comb begin
        for (int i = 0; i < NUM_DRIVE; i++) begin
            ctrl_we[i] = write_en && (bcast_hit || (address == drive_addr(i, 1'b0)));
        end
    end

    // Control bytes, motor fields update the edge after the write
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            drive_ctrl <= '0;  // Motors released, zero PWM
        end else begin
            for (int i = 0; i < NUM_DRIVE; i++) begin
                if (ctrl_we[i]) begin
                    drive_ctrl[i] <= wr_data;
                end
            end
        end
    end

    // Status follows the motor pins every clock
    always_ff @(posedge clock) begin
        for (int i = 0; i < NUM_DRIVE; i++) begin
            drive_status[i] <= {fault[i], startup_fail[i], adc_temp[i]};  // 1+1+6 bits
        end
    end

endmodule

//--- source/rotation_bank.sv
/*
 * Rotation motor registers: control, target low, command pulses and angle snapshots.
 * Contents reach the read mux through rot_readback_if.
 */
`timescale 1ns/1ps

module rotation_bank
    import swerve_types_pkg::*, swerve_map_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  addr_t                 address,        // Host register address
    input  logic                  write_en,       // Host write strobe
    input  data_t                 wr_data,        // Host write byte
    input  angle_t [NUM_ROT-1:0]  current_angle,  // Live encoder angle
    input  logic   [NUM_ROT-1:0]  angle_done,     // Unit reached its target
    output logic   [NUM_ROT-1:0]  update_angle,   // One-clock start pulse
    output logic   [NUM_ROT-1:0]  abort_angle,    // One-clock abort pulse
    rot_readback_if.bank          rb              // Register contents for readback
);

    logic               bcast_hit;  // Write lands on every rotation control
    logic [NUM_ROT-1:0] ctrl_we;
    logic [NUM_ROT-1:0] tgt_we;
    logic [NUM_ROT-1:0] cmd_we;     // Command slot written

    assign bcast_hit = (address == ADDR_BCAST_ALL) || (address == ADDR_BCAST_ROT);

    // Per-unit decode
    always_comb begin
        for (int i = 0; i < NUM_ROT; i++) begin
            ctrl_we[i] = write_en && (bcast_hit || (address == rot_addr(i, ROT_OFS_CTRL)));
            tgt_we[i]  = write_en && (address == rot_addr(i, ROT_OFS_TGT_LO));
            cmd_we[i]  = write_en && (address == rot_addr(i, ROT_OFS_CMD));
            // Current-low slot is read only, no write enable
        end
    end

    // Control and target bytes
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rb.rot_ctrl   <= '0;
            rb.rot_tgt_lo <= '0;
        end else begin
            for (int i = 0; i < NUM_ROT; i++) begin
                if (ctrl_we[i]) begin
                    rb.rot_ctrl[i] <= wr_data;
                end
                if (tgt_we[i]) begin
                    rb.rot_tgt_lo[i] <= wr_data;
                end
            end
        end
    end

    // Command decode, pulses are high only in the clock after the write
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            update_angle <= '0;
            abort_angle  <= '0;
        end else begin
            for (int i = 0; i < NUM_ROT; i++) begin
                update_angle[i] <= cmd_we[i] && wr_data[BIT_UPDATE];
                abort_angle[i]  <= cmd_we[i] && wr_data[BIT_ABORT];
            end
        end
    end

    // Snapshot holds both angle bytes from one instant
    // Host reads low then high without tearing
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rb.rot_snap <= '0;
        end else begin
            for (int i = 0; i < NUM_ROT; i++) begin
                if (cmd_we[i] && wr_data[BIT_SNAP]) begin
                    rb.rot_snap[i] <= current_angle[i];  // Same edge as the write
                end
            end
        end
    end

    // Done flags sampled every clock
    always_ff @(posedge clock) begin
        rb.rot_done <= angle_done;
    end

endmodule

//--- source/reg_read_mux.sv
/*
 * Read side of the register block: address decode over both banks into rd_data.
 * rd_data loads only on read_en and holds otherwise.
 */
`timescale 1ns/1ps

module reg_read_mux
    import swerve_types_pkg::*, swerve_map_pkg::*;
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  addr_t                 address,       // Host register address
    input  logic                  read_en,       // Host read strobe
    input  data_t [NUM_DRIVE-1:0] drive_ctrl,    // From drive bank
    input  data_t [NUM_DRIVE-1:0] drive_status,
    rot_readback_if.mux           rb,            // From rotation bank
    output data_t                 rd_data        // Registered read byte
);

    data_t rd_next;  // Byte selected by address

    always_comb begin
        angle_hi_t snap_hi;
        data_t     snap_lo;
        data_t     cmd_byte;

        rd_next  = '0;  // Unmapped and broadcast slots read 0
        snap_hi  = '0;
        snap_lo  = '0;
        cmd_byte = '0;

        for (int i = 0; i < NUM_DRIVE; i++) begin
            if (address == drive_addr(i, 1'b0)) rd_next = drive_ctrl[i];
            if (address == drive_addr(i, 1'b1)) rd_next = drive_status[i];
        end

        for (int i = 0; i < NUM_ROT; i++) begin
            {snap_hi, snap_lo} = rb.rot_snap[i];
            cmd_byte           = data_t'(snap_hi);  // Bits 6..4 stay zero
            cmd_byte[BIT_DONE] = rb.rot_done[i];

            if (address == rot_addr(i, ROT_OFS_CTRL))   rd_next = rb.rot_ctrl[i];
            if (address == rot_addr(i, ROT_OFS_TGT_LO)) rd_next = rb.rot_tgt_lo[i];
            if (address == rot_addr(i, ROT_OFS_CUR_LO)) rd_next = snap_lo;
            if (address == rot_addr(i, ROT_OFS_CMD))    rd_next = cmd_byte;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (read_en) begin
            rd_data <= rd_next;  // Visible one clock after the strobe
        end
    end

endmodule

//--- source/swerve_reg_file.sv
/*
 * Top of the swerve-drive register block: host strobe bus in, per-motor pins out.
 * Wires the drive bank, rotation bank and read mux, and splits bytes into motor fields.
 */
`timescale 1ns/1ps

module swerve_reg_file
    import swerve_types_pkg::*, swerve_map_pkg::*;
(
    input  logic clock,
    input  logic rst_n,
    input  addr_t address,   // Host register address
    input  logic  write_en,  // Host write strobe
    input  data_t wr_data,
    input  logic  read_en,   // Host read strobe
    output data_t rd_data,   // Valid the clock after read_en

    // Drive motors 0..3
    input  logic  fault0, fault1, fault2, fault3,
    input  logic  [NUM_DRIVE-1:0] startup_fail,  // Bit i for drive unit i
    input  temp_t adc_temp0, adc_temp1, adc_temp2, adc_temp3,
    output logic  brake0, brake1, brake2, brake3,
    output logic  enable0, enable1, enable2, enable3,
    output logic  direction0, direction1, direction2, direction3,
    output pwm_t  pwm0, pwm1, pwm2, pwm3,

    // Rotation motors 0..3, pins 4..7 for brake, enable, direction
    output logic   brake4, brake5, brake6, brake7,
    output logic   enable4, enable5, enable6, enable7,
    output logic   direction4, direction5, direction6, direction7,
    output angle_t target_angle0, target_angle1, target_angle2, target_angle3,
    input  angle_t current_angle0, current_angle1, current_angle2, current_angle3,
    output logic   update_angle0, update_angle1, update_angle2, update_angle3,
    output logic   abort_angle0, abort_angle1, abort_angle2, abort_angle3,
    input  logic   angle_done0, angle_done1, angle_done2, angle_done3
);

    data_t [NUM_DRIVE-1:0] drive_ctrl;
    data_t [NUM_DRIVE-1:0] drive_status;
    logic  [NUM_ROT-1:0]   update_angle;
    logic  [NUM_ROT-1:0]   abort_angle;

    rot_readback_if rb_if ();

    drive_bank u_drive_bank (
        .clock        (clock),
        .rst_n        (rst_n),
        .address      (address),
        .write_en     (write_en),
        .wr_data      (wr_data),
        .fault        ({fault3, fault2, fault1, fault0}),
        .startup_fail (startup_fail),
        .adc_temp     ({adc_temp3, adc_temp2, adc_temp1, adc_temp0}),
        .drive_ctrl   (drive_ctrl),
        .drive_status (drive_status)
    );

    rotation_bank u_rotation_bank (
        .clock         (clock),
        .rst_n         (rst_n),
        .address       (address),
        .write_en      (write_en),
        .wr_data       (wr_data),
        .current_angle ({current_angle3, current_angle2, current_angle1, current_angle0}),
        .angle_done    ({angle_done3, angle_done2, angle_done1, angle_done0}),
        .update_angle  (update_angle),
        .abort_angle   (abort_angle),
        .rb            (rb_if.bank)
    );

    reg_read_mux u_reg_read_mux (
        .clock        (clock),
        .rst_n        (rst_n),
        .address      (address),
        .read_en      (read_en),
        .drive_ctrl   (drive_ctrl),
        .drive_status (drive_status),
        .rb           (rb_if.mux),
        .rd_data      (rd_data)
    );

    // Drive control fields
    assign {brake3, brake2, brake1, brake0} = {drive_ctrl[3][BIT_BRAKE],
        drive_ctrl[2][BIT_BRAKE], drive_ctrl[1][BIT_BRAKE], drive_ctrl[0][BIT_BRAKE]};
    assign {enable3, enable2, enable1, enable0} = {drive_ctrl[3][BIT_ENABLE],
        drive_ctrl[2][BIT_ENABLE], drive_ctrl[1][BIT_ENABLE], drive_ctrl[0][BIT_ENABLE]};
    assign {direction3, direction2, direction1, direction0} = {drive_ctrl[3][BIT_DIRECTION],
        drive_ctrl[2][BIT_DIRECTION], drive_ctrl[1][BIT_DIRECTION],
        drive_ctrl[0][BIT_DIRECTION]};
    assign pwm0 = pwm_t'(drive_ctrl[0]);  // Low five bits
    assign pwm1 = pwm_t'(drive_ctrl[1]);
    assign pwm2 = pwm_t'(drive_ctrl[2]);
    assign pwm3 = pwm_t'(drive_ctrl[3]);

    // Rotation control fields
    assign {brake7, brake6, brake5, brake4} = {rb_if.rot_ctrl[3][BIT_BRAKE],
        rb_if.rot_ctrl[2][BIT_BRAKE], rb_if.rot_ctrl[1][BIT_BRAKE],
        rb_if.rot_ctrl[0][BIT_BRAKE]};
    assign {enable7, enable6, enable5, enable4} = {rb_if.rot_ctrl[3][BIT_ENABLE],
        rb_if.rot_ctrl[2][BIT_ENABLE], rb_if.rot_ctrl[1][BIT_ENABLE],
        rb_if.rot_ctrl[0][BIT_ENABLE]};
    assign {direction7, direction6, direction5, direction4} = {
        rb_if.rot_ctrl[3][BIT_DIRECTION], rb_if.rot_ctrl[2][BIT_DIRECTION],
        rb_if.rot_ctrl[1][BIT_DIRECTION], rb_if.rot_ctrl[0][BIT_DIRECTION]};

    // Target is control bits 3..0 over the low byte
    assign target_angle0 = {angle_hi_t'(rb_if.rot_ctrl[0]), rb_if.rot_tgt_lo[0]};
    assign target_angle1 = {angle_hi_t'(rb_if.rot_ctrl[1]), rb_if.rot_tgt_lo[1]};
    assign target_angle2 = {angle_hi_t'(rb_if.rot_ctrl[2]), rb_if.rot_tgt_lo[2]};
    assign target_angle3 = {angle_hi_t'(rb_if.rot_ctrl[3]), rb_if.rot_tgt_lo[3]};

    assign {update_angle3, update_angle2, update_angle1, update_angle0} = update_angle;
    assign {abort_angle3, abort_angle2, abort_angle1, abort_angle0}     = abort_angle;

endmodule

//--- sim/tb_swerve_reg_file.sv
/*
 * Testbench for the swerve register block: LFSR stimulus on the host bus, register model,
 * per-test result lines and a watchdog. Run through the Makefile in the project root.
 */
`timescale 1ns/1ps

module tb_swerve_reg_file;

    localparam int N_WRITES = 48;  // Random control and target writes
    localparam int N_STATUS = 6;   // Status input sets
    localparam int N_CMD    = 12;  // Command pulse writes
    localparam int N_JUNK   = 10;  // Writes outside the map
    localparam int N_EMPTY  = 40;  // Reads of 0x00..0x03 and 0x1C..0x3F
    // Clocks per test, every bus access takes two
    localparam int BUDGET = 16 + 12 * 2 + N_WRITES * 2 + 12 * 2 + N_STATUS * 10
                          + N_CMD * 3 + 4 * 10 + N_JUNK * 2 + N_EMPTY * 2;
    localparam int MARGIN = 200;

    logic             clock;
    logic             rst_n;
    logic [5:0]       address;
    logic             write_en;
    logic [7:0]       wr_data;
    logic             read_en;
    wire  [7:0]       rd_data;
    logic [3:0]       fault;
    logic [3:0]       startup_fail;
    logic [3:0][5:0]  adc_temp;
    logic [3:0][11:0] current_angle;
    logic [3:0]       angle_done;
    wire  [7:0]       brake;         // 0..3 drive, 4..7 rotation
    wire  [7:0]       enable;
    wire  [7:0]       direction;
    wire  [3:0][4:0]  pwm;
    wire  [3:0][11:0] target_angle;
    wire  [3:0]       update_angle;
    wire  [3:0]       abort_angle;

    // Register model
    logic [7:0]  exp_drive [4];  // Drive control bytes
    logic [7:0]  exp_rot [4];    // Rotation control bytes
    logic [7:0]  exp_tgt [4];    // Target low bytes
    logic [11:0] exp_snap [4];   // Captured angles

    logic [31:0] lfsr = 32'h37bc;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          err_mark;       // Error count at test start

    swerve_reg_file u_swerve_reg_file (
        .clock(clock), .rst_n(rst_n), .address(address), .write_en(write_en),
        .wr_data(wr_data), .read_en(read_en), .rd_data(rd_data),
        .fault0(fault[0]), .fault1(fault[1]), .fault2(fault[2]), .fault3(fault[3]),
        .startup_fail(startup_fail),
        .adc_temp0(adc_temp[0]), .adc_temp1(adc_temp[1]),
        .adc_temp2(adc_temp[2]), .adc_temp3(adc_temp[3]),
        .brake0(brake[0]), .brake1(brake[1]), .brake2(brake[2]), .brake3(brake[3]),
        .enable0(enable[0]), .enable1(enable[1]), .enable2(enable[2]), .enable3(enable[3]),
        .direction0(direction[0]), .direction1(direction[1]),
        .direction2(direction[2]), .direction3(direction[3]),
        .pwm0(pwm[0]), .pwm1(pwm[1]), .pwm2(pwm[2]), .pwm3(pwm[3]),
        .brake4(brake[4]), .brake5(brake[5]), .brake6(brake[6]), .brake7(brake[7]),
        .enable4(enable[4]), .enable5(enable[5]), .enable6(enable[6]), .enable7(enable[7]),
        .direction4(direction[4]), .direction5(direction[5]),
        .direction6(direction[6]), .direction7(direction[7]),
        .target_angle0(target_angle[0]), .target_angle1(target_angle[1]),
        .target_angle2(target_angle[2]), .target_angle3(target_angle[3]),
        .current_angle0(current_angle[0]), .current_angle1(current_angle[1]),
        .current_angle2(current_angle[2]), .current_angle3(current_angle[3]),
        .update_angle0(update_angle[0]), .update_angle1(update_angle[1]),
        .update_angle2(update_angle[2]), .update_angle3(update_angle[3]),
        .abort_angle0(abort_angle[0]), .abort_angle1(abort_angle[1]),
        .abort_angle2(abort_angle[2]), .abort_angle3(abort_angle[3]),
        .angle_done0(angle_done[0]), .angle_done1(angle_done[1]),
        .angle_done2(angle_done[2]), .angle_done3(angle_done[3])
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;  // 10 ns period
    end

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    // k 0..3 drive ctrl, 4..7 rotation ctrl, 8..11 target low
    function automatic logic [5:0] ctrl_tgt_addr(input int k);
        if (k < 4) return 6'(4 + 2 * k);
        if (k < 8) return 6'(12 + 4 * (k - 4));
        return 6'(13 + 4 * (k - 8));
    endfunction

    // Write rules of the map, broadcasts included
    task automatic model_write(input logic [5:0] addr, input logic [7:0] data);
        int a;
        a = int'(addr);
        for (int i = 0; i < 4; i++) begin
            if (a == 1 || a == 3 || a == 4 + 2 * i) exp_drive[i] = data;
            if (a == 1 || a == 2 || a == 12 + 4 * i) exp_rot[i] = data;
            if (a == 13 + 4 * i) exp_tgt[i] = data;
        end
    endtask

    // Read byte of an address from the model and the held inputs
    function automatic logic [7:0] expected_byte(input logic [5:0] addr);
        int a;
        int unit;
        a = int'(addr);
        if (a >= 4 && a <= 11) begin
            unit = (a - 4) / 2;
            if (a % 2 == 0) return exp_drive[unit];
            return {fault[unit], startup_fail[unit], adc_temp[unit]};  // Status layout
        end
        if (a >= 12 && a <= 27) begin
            unit = (a - 12) / 4;
            case (a % 4)
                0: return exp_rot[unit];
                1: return exp_tgt[unit];
                2: return exp_snap[unit][7:0];
                default: return {angle_done[unit], 3'b000, exp_snap[unit][11:8]};
            endcase
        end
        return 8'h00;  // Unmapped and broadcast
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %s got 0x%0h exp 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic bus_write(input logic [5:0] addr, input logic [7:0] data);
        @(posedge clock);
        #1;
        address  = addr;
        write_en = 1'b1;
        wr_data  = data;
        @(posedge clock);  // Register loads here
        #1;
        write_en = 1'b0;
        model_write(addr, data);
    endtask

    task automatic bus_read(input logic [5:0] addr, output logic [7:0] data);
        @(posedge clock);
        #1;
        address = addr;
        read_en = 1'b1;
        @(posedge clock);
        #1;
        read_en = 1'b0;
        data    = rd_data;  // Loaded on the strobe edge
    endtask

    task automatic read_check(input logic [5:0] addr, input logic [7:0] exp);
        logic [7:0] got;
        bus_read(addr, got);
        check_value($sformatf("rd_data[0x%02h]", addr), 32'(got), 32'(exp));
    endtask

    // Every motor field against the model
    task automatic check_outputs();
        for (int i = 0; i < 4; i++) begin
            check_value($sformatf("brake%0d", i), 32'(brake[i]), 32'(exp_drive[i][7]));
            check_value($sformatf("enable%0d", i), 32'(enable[i]), 32'(exp_drive[i][6]));
            check_value($sformatf("direction%0d", i), 32'(direction[i]),
                        32'(exp_drive[i][5]));
            check_value($sformatf("pwm%0d", i), 32'(pwm[i]), 32'(exp_drive[i][4:0]));
            check_value($sformatf("brake%0d", i + 4), 32'(brake[i + 4]), 32'(exp_rot[i][7]));
            check_value($sformatf("enable%0d", i + 4), 32'(enable[i + 4]),
                        32'(exp_rot[i][6]));
            check_value($sformatf("direction%0d", i + 4), 32'(direction[i + 4]),
                        32'(exp_rot[i][5]));
            check_value($sformatf("target_angle%0d", i), 32'(target_angle[i]),
                        32'({exp_rot[i][3:0], exp_tgt[i]}));
        end
    endtask

    task automatic check_pulses(input logic [3:0] upd, input logic [3:0] abt);
        check_value("update_angle", 32'(update_angle), 32'(upd));
        check_value("abort_angle", 32'(abort_angle), 32'(abt));
    endtask

    task automatic sweep_ctrl_reads();
        for (int k = 0; k < 12; k++) begin
            read_check(ctrl_tgt_addr(k), expected_byte(ctrl_tgt_addr(k)));
        end
    endtask

    task automatic start_test();
        err_mark = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %-10s %s (%0d errors)", name,
                 (errors == err_mark) ? "ok" : "failing", errors - err_mark);
    endtask

    // Watchdog sized from the test lengths
    initial begin
        repeat (BUDGET + MARGIN) @(posedge clock);
        $display("Timeout after %0d clocks, the tests did not complete", BUDGET + MARGIN);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [5:0] addr;
        logic [3:0] unit;
        logic       upd;
        logic       abt;

        rst_n         = 1'b0;
        address       = '0;
        write_en      = 1'b0;
        wr_data       = '0;
        read_en       = 1'b0;
        fault         = '0;
        startup_fail  = '0;
        adc_temp      = '0;
        current_angle = '0;
        angle_done    = '0;
        for (int i = 0; i < 4; i++) begin
            exp_drive[i] = '0;
            exp_rot[i]   = '0;
            exp_tgt[i]   = '0;
            exp_snap[i]  = '0;
        end
        repeat (16) @(posedge clock);
        #1;
        rst_n = 1'b1;

        start_test();  // Reset values
        check_outputs();
        check_pulses(4'h0, 4'h0);
        sweep_ctrl_reads();
        end_test("reset");

        start_test();  // Random writes, broadcasts at idx 0..2
        for (int n = 0; n < N_WRITES; n++) begin
            int idx;
            idx  = int'(take_bits(4)) % 15;
            addr = (idx < 3) ? 6'(idx + 1) : ctrl_tgt_addr(idx - 3);
            bus_write(addr, 8'(take_bits(8)));
            check_outputs();
        end
        sweep_ctrl_reads();
        end_test("writes");

        start_test();
        for (int n = 0; n < N_STATUS; n++) begin
            fault        = 4'(take_bits(4));
            startup_fail = 4'(take_bits(4));
            for (int i = 0; i < 4; i++) adc_temp[i] = 6'(take_bits(6));
            repeat (2) @(posedge clock);  // Held while sampled and read
            #1;
            for (int i = 0; i < 4; i++) begin
                read_check(6'(5 + 2 * i), expected_byte(6'(5 + 2 * i)));
            end
        end
        end_test("status");

        start_test();  // Pulses only in the clock after the write edge
        for (int n = 0; n < N_CMD; n++) begin
            unit = 4'(take_bits(2));
            upd  = take_bits(1) != 0;
            abt  = take_bits(1) != 0;
            @(posedge clock);
            #1;
            address  = 6'(15 + 4 * unit);
            write_en = 1'b1;
            wr_data  = {2'b00, upd, abt, 4'h0};
            check_pulses(4'h0, 4'h0);
            @(posedge clock);
            #1;
            write_en = 1'b0;
            check_pulses(upd ? 4'(1 << unit) : 4'h0, abt ? 4'(1 << unit) : 4'h0);
            @(posedge clock);
            #1;
            check_pulses(4'h0, 4'h0);
        end
        check_outputs();
        end_test("commands");

        start_test();
        for (int u = 0; u < 4; u++) begin
            for (int i = 0; i < 4; i++) current_angle[i] = 12'(take_bits(12));
            angle_done = 4'(take_bits(4));
            bus_write(6'(15 + 4 * u), 8'h40);  // Snapshot bit only
            exp_snap[u] = current_angle[u];
            for (int i = 0; i < 4; i++) current_angle[i] = 12'(take_bits(12));
            read_check(6'(14 + 4 * u), expected_byte(6'(14 + 4 * u)));
            read_check(6'(15 + 4 * u), expected_byte(6'(15 + 4 * u)));
        end
        end_test("snapshot");

        start_test();  // Outside the map
        for (int n = 0; n < N_JUNK; n++) begin
            addr = (n == 0) ? 6'h00 : 6'(28 + int'(take_bits(6)) % 36);
            bus_write(addr, 8'(take_bits(8)));
            check_outputs();
            check_pulses(4'h0, 4'h0);
        end
        for (int a = 0; a < 64; a++) begin
            if (a < 4 || a >= 28) read_check(6'(a), 8'h00);
        end
        end_test("unmapped");

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- swerve_reg_file.f
source/swerve_types_pkg.sv
source/swerve_map_pkg.sv
source/rot_readback_if.sv
source/drive_bank.sv
source/rotation_bank.sv
source/reg_read_mux.sv
source/swerve_reg_file.sv
sim/tb_swerve_reg_file.sv

//--- Makefile
# Verilator build and run of the swerve register block testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_swerve_reg_file
FILELIST  := swerve_reg_file.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
